// File: verilog/periph_pkg.sv
// Shared definitions for the peripheral bus in the video clock domain.
// Holds the address map, the region codes and the packed structs that
// carry the processor request, the bus response and the decoded strobe.

`default_nettype none

package periph_pkg;

    // processor address width
    localparam int addr_width = 24;

    // copper RAM word address width
    localparam int cop_addr_width = 11;

    // region code taken from address bits 23..20
    typedef enum logic [3:0] {
        region_status = 4'd1,
        region_dsp    = 4'd2,
        region_pad    = 4'd3,
        region_copper = 4'd4
    } region_t;

    // processor memory port, held until ready is seen
    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] address;
        logic [3:0]            wstrb;
        logic [31:0]           write_data;
    } bus_request_t;

    // read data is only meaningful while ready is high
    typedef struct packed {
        logic        ready;
        logic [31:0] read_data;
    } bus_response_t;

    // one-cycle decoded access, at most one enable set
    typedef struct packed {
        logic                  status_en;
        logic                  dsp_en;
        logic                  pad_en;
        logic                  copper_en;
        logic                  write;
        logic                  unmapped;
        logic [addr_width-1:0] address;
        logic [3:0]            wstrb;
        logic [31:0]           write_data;
    } periph_strobe_t;

endpackage

`default_nettype wire

// File: verilog/address_decoder.sv
// Address decoder for the peripheral bus.
// Turns a held processor request into a single-cycle strobe for one region.
// With registered_inputs set the strobe comes one cycle later from a register.

`timescale 1ns/1ps
`default_nettype none

module address_decoder #(
    parameter bit registered_inputs = 1'b1
) (
    input  logic                       vdp_clk,
    input  logic                       vdp_reset,
    input  periph_pkg::bus_request_t   req,
    output periph_pkg::periph_strobe_t strobe
);

    periph_pkg::region_t        region;
    periph_pkg::periph_strobe_t strobe_next;
    logic                       busy;
    logic                       issue;

    assign region = periph_pkg::region_t'(req.address[periph_pkg::addr_width-1 -: 4]);

    // only the first cycle of a held request counts
    assign issue = req.valid && !busy;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            busy <= 1'b0;
        end else if (!req.valid) begin
            busy <= 1'b0;
        end else if (issue) begin
            busy <= 1'b1;
        end
    end

    always_comb begin
        strobe_next            = '0;
        strobe_next.address    = req.address;
        strobe_next.wstrb      = req.wstrb;
        strobe_next.write_data = req.write_data;
        if (issue) begin
            strobe_next.write = |req.wstrb;
            case (region)
                periph_pkg::region_status: strobe_next.status_en = 1'b1;
                periph_pkg::region_dsp:    strobe_next.dsp_en    = 1'b1;
                periph_pkg::region_pad:    strobe_next.pad_en    = 1'b1;
                periph_pkg::region_copper: strobe_next.copper_en = 1'b1;
                // still answered so the processor does not hang
                default:                   strobe_next.unmapped  = 1'b1;
            endcase
        end
    end

    generate
        if (registered_inputs) begin : g_registered
            periph_pkg::periph_strobe_t strobe_q;

            always_ff @(posedge vdp_clk) begin
                strobe_q.address    <= strobe_next.address;
                strobe_q.wstrb      <= strobe_next.wstrb;
                strobe_q.write_data <= strobe_next.write_data;
                if (vdp_reset) begin
                    strobe_q.status_en <= 1'b0;
                    strobe_q.dsp_en    <= 1'b0;
                    strobe_q.pad_en    <= 1'b0;
                    strobe_q.copper_en <= 1'b0;
                    strobe_q.write     <= 1'b0;
                    strobe_q.unmapped  <= 1'b0;
                end else begin
                    strobe_q.status_en <= strobe_next.status_en;
                    strobe_q.dsp_en    <= strobe_next.dsp_en;
                    strobe_q.pad_en    <= strobe_next.pad_en;
                    strobe_q.copper_en <= strobe_next.copper_en;
                    strobe_q.write     <= strobe_next.write;
                    strobe_q.unmapped  <= strobe_next.unmapped;
                end
            end

            assign strobe = strobe_q;
        end else begin : g_combinational
            assign strobe = strobe_next;
        end
    endgenerate

endmodule

`default_nettype wire

// File: verilog/dsp_multiplier.sv
// Memory mapped signed 16x16 multiplier.
// Address bit 2 picks operand a or b, a read returns the 32-bit product.

`timescale 1ns/1ps
`default_nettype none

module dsp_multiplier (
    input  logic                       vdp_clk,
    input  periph_pkg::periph_strobe_t strobe,
    output logic [31:0]                product
);

    logic signed [15:0] mult_a;
    logic signed [15:0] mult_b;
    logic               dsp_write;

    assign dsp_write = strobe.dsp_en && strobe.write;

    // flat enables so the operand registers fold into the MAC block
    always_ff @(posedge vdp_clk) begin
        if (dsp_write && !strobe.address[2]) begin
            mult_a <= strobe.write_data[15:0];
        end

        if (dsp_write && strobe.address[2]) begin
            mult_b <= strobe.write_data[15:0];
        end

        // product register free runs
        product <= 32'(mult_a * mult_b);
    end

endmodule

`default_nettype wire

// File: verilog/gamepad_reader.sv
// Mock gamepad built from three board buttons.
// The processor drives latch and pad clock through pad_ctrl and reads the
// serial data bit, the same way it would talk to a real pad shift register.

`timescale 1ns/1ps
`default_nettype none

module gamepad_reader (
    input  logic                       vdp_clk,
    input  logic                       vdp_reset,
    input  periph_pkg::periph_strobe_t strobe,
    input  logic                       btn1,
    input  logic                       btn2,
    input  logic                       btn3,
    output logic [1:0]                 pad_data
);

    logic [1:0]  pad_ctrl;
    logic [15:0] pad_state;
    logic        pad_latch;
    logic        pad_clk;
    logic        pad_clk_r;

    assign pad_latch = pad_ctrl[0];
    assign pad_clk   = pad_ctrl[1];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_ctrl  <= 2'b00;
            pad_clk_r <= 1'b0;
        end else begin
            if (strobe.pad_en && strobe.write) begin
                pad_ctrl <= strobe.write_data[1:0];
            end
            pad_clk_r <= pad_clk;
        end
    end

    always_ff @(posedge vdp_clk) begin
        // left, right and B buttons
        if (pad_latch) begin
            pad_state <= {8'b0, btn1, btn3, 5'b0, btn2};
        end

        // shift on rising pad clock
        if (pad_clk && !pad_clk_r) begin
            pad_state <= {1'b0, pad_state[15:1]};
        end
    end

    // second data line unused on the mock
    assign pad_data = {1'b0, pad_state[0]};

endmodule

`default_nettype wire

// File: verilog/copper_ram.sv
// Copper program RAM, 2048 words of 16 bits.
// Written by the processor through the bus, read by the video side
// through its own registered port.

`timescale 1ns/1ps
`default_nettype none

module copper_ram (
    input  logic                                vdp_clk,
    input  periph_pkg::periph_strobe_t          strobe,
    input  logic [periph_pkg::cop_addr_width-1:0] cop_read_address,
    output logic [15:0]                         cop_read_data
);

    localparam int depth = 1 << periph_pkg::cop_addr_width;

    logic [15:0] mem [0:depth-1];

    logic [periph_pkg::cop_addr_width-1:0] write_address;
    logic                                  write_en;

    // halfword select comes from the upper strobe bit
    assign write_address = {strobe.address[11:2], strobe.wstrb[2]};
    assign write_en      = strobe.copper_en && strobe.write;

    always_ff @(posedge vdp_clk) begin
        if (write_en) begin
            mem[write_address] <= strobe.write_data[15:0];
        end

        cop_read_data <= mem[cop_read_address];
    end

endmodule

`default_nettype wire

// File: verilog/bus_responder.sv
// Response side of the peripheral bus.
// Holds the LED status register, picks the read data for the strobed
// region and returns it with a one-cycle ready pulse on the next cycle.

`timescale 1ns/1ps
`default_nettype none

module bus_responder (
    input  logic                       vdp_clk,
    input  logic                       vdp_reset,
    input  periph_pkg::periph_strobe_t strobe,
    input  logic [31:0]                product,
    input  logic [1:0]                 pad_data,
    output periph_pkg::bus_response_t  rsp,
    output logic                       led_r,
    output logic                       led_b
);

    logic [1:0]  status;
    logic [31:0] read_next;
    logic        strobe_active;
    logic        ready_q;
    logic [31:0] read_data_q;

    assign strobe_active = strobe.status_en || strobe.dsp_en || strobe.pad_en ||
                           strobe.copper_en || strobe.unmapped;

    // status register, red LED on out of reset
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= 2'b01;
        end else if (strobe.status_en && strobe.write) begin
            status <= strobe.write_data[1:0];
        end
    end

    assign led_r = status[0];
    assign led_b = status[1];

    // copper and unmapped fall through to zero
    always_comb begin
        read_next = 32'b0;
        if (!strobe.write) begin
            if (strobe.status_en) begin
                read_next = {30'b0, status};
            end else if (strobe.dsp_en) begin
                read_next = product;
            end else if (strobe.pad_en) begin
                read_next = {30'b0, pad_data};
            end
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= strobe_active;
        end
    end

    always_ff @(posedge vdp_clk) begin
        read_data_q <= read_next;
    end

    assign rsp.ready     = ready_q;
    assign rsp.read_data = read_data_q;

endmodule

`default_nettype wire

// File: verilog/peripheral_bus.sv
// Top level of the peripheral bus in the video clock domain.
// Connects the address decoder, the multiplier, gamepad and copper RAM,
// and the responder that answers the processor memory port.

`timescale 1ns/1ps
`default_nettype none

module peripheral_bus #(
    parameter bit registered_inputs = 1'b1
) (
    input  logic                                  vdp_clk,
    input  logic                                  vdp_reset,
    input  periph_pkg::bus_request_t              req,
    output periph_pkg::bus_response_t             rsp,
    input  logic                                  btn1,
    input  logic                                  btn2,
    input  logic                                  btn3,
    output logic                                  led_r,
    output logic                                  led_b,
    input  logic [periph_pkg::cop_addr_width-1:0] cop_read_address,
    output logic [15:0]                           cop_read_data
);

    periph_pkg::periph_strobe_t strobe;
    logic [31:0]                product;
    logic [1:0]                 pad_data;

    // decode
    address_decoder #(
        .registered_inputs(registered_inputs)
    ) i_address_decoder (
        .vdp_clk  (vdp_clk),
        .vdp_reset(vdp_reset),
        .req      (req),
        .strobe   (strobe)
    );

    // execute
    dsp_multiplier i_dsp_multiplier (
        .vdp_clk(vdp_clk),
        .strobe (strobe),
        .product(product)
    );

    gamepad_reader i_gamepad_reader (
        .vdp_clk  (vdp_clk),
        .vdp_reset(vdp_reset),
        .strobe   (strobe),
        .btn1     (btn1),
        .btn2     (btn2),
        .btn3     (btn3),
        .pad_data (pad_data)
    );

    // video side reads through its own port
    copper_ram i_copper_ram (
        .vdp_clk         (vdp_clk),
        .strobe          (strobe),
        .cop_read_address(cop_read_address),
        .cop_read_data   (cop_read_data)
    );

    // result
    bus_responder i_bus_responder (
        .vdp_clk  (vdp_clk),
        .vdp_reset(vdp_reset),
        .strobe   (strobe),
        .product  (product),
        .pad_data (pad_data),
        .rsp      (rsp),
        .led_r    (led_r),
        .led_b    (led_b)
    );

endmodule

`default_nettype wire

// File: bench/peripheral_bus_asserts.sv
// Concurrent checks on the decoded strobe and the ready pulse.
// Bound into the responder, which sees the decoder strobe and the response.

`timescale 1ns/1ps
`default_nettype none

module peripheral_bus_asserts (
    input logic                       vdp_clk,
    input logic                       vdp_reset,
    input periph_pkg::periph_strobe_t strobe,
    input periph_pkg::bus_response_t  rsp
);

    logic strobe_active;
    int   failure_count = 0;

    assign strobe_active = strobe.status_en || strobe.dsp_en || strobe.pad_en ||
                           strobe.copper_en || strobe.unmapped;

    // at most one region per strobe
    one_region: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $onehot0({strobe.status_en, strobe.dsp_en, strobe.pad_en,
                  strobe.copper_en, strobe.unmapped}))
        else begin
            failure_count++;
            $error("more than one strobe enable set");
        end

    // responder answers on the next cycle
    ready_after_strobe: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        strobe_active |=> rsp.ready)
        else begin
            failure_count++;
            $error("ready missing one cycle after strobe");
        end

    single_ready: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        rsp.ready |=> !rsp.ready)
        else begin
            failure_count++;
            $error("ready high two cycles in a row");
        end

endmodule

bind bus_responder peripheral_bus_asserts i_peripheral_bus_asserts (
    .vdp_clk  (vdp_clk),
    .vdp_reset(vdp_reset),
    .strobe   (strobe),
    .rsp      (rsp)
);

`default_nettype wire

// File: bench/tb_peripheral_bus.sv
// Testbench for the peripheral bus top level.
// Reads operations and expected values from the golden file, plays the
// processor memory port and the copper video port, and checks responses.

`timescale 1ns/1ps
`default_nettype none

module tb_peripheral_bus;

    localparam int ready_timeout = 20;
    localparam int expected_latency = 2;
    localparam logic [23:0] pad_address = 24'h300000;

    logic                                  vdp_clk;
    logic                                  vdp_reset;
    periph_pkg::bus_request_t              req;
    periph_pkg::bus_response_t             rsp;
    logic                                  btn1;
    logic                                  btn2;
    logic                                  btn3;
    logic                                  led_r;
    logic                                  led_b;
    logic [periph_pkg::cop_addr_width-1:0] cop_read_address;
    logic [15:0]                           cop_read_data;

    int          check_count;
    int          error_count;
    int          assert_failures;
    bit          timed_out;
    int          fd;
    int          got;
    int          fields;
    string       line;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] strb;
    logic [31:0] data;

    peripheral_bus #(
        .registered_inputs(1'b1)
    ) i_dut (
        .vdp_clk         (vdp_clk),
        .vdp_reset       (vdp_reset),
        .req             (req),
        .rsp             (rsp),
        .btn1            (btn1),
        .btn2            (btn2),
        .btn3            (btn3),
        .led_r           (led_r),
        .led_b           (led_b),
        .cop_read_address(cop_read_address),
        .cop_read_data   (cop_read_data)
    );

    initial begin
        vdp_clk = 1'b0;
        forever #4 vdp_clk = ~vdp_clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // holds one request until ready and drops valid on the next edge
    task automatic bus_access(input logic [23:0] address, input logic [3:0] wstrb,
                              input logic [31:0] write_data, output logic [31:0] read_data);
        int latency;
        read_data = '0;
        latency = 0;
        if (timed_out) begin
            return;
        end
        @(posedge vdp_clk);
        req.valid      <= 1'b1;
        req.address    <= address;
        req.wstrb      <= wstrb;
        req.write_data <= write_data;
        @(negedge vdp_clk);
        while (!rsp.ready && !timed_out) begin
            if (latency >= ready_timeout) begin
                $display("timeout waiting for ready, address %h", address);
                timed_out = 1'b1;
            end else begin
                @(posedge vdp_clk);
                latency++;
                @(negedge vdp_clk);
            end
        end
        if (!timed_out) begin
            read_data = rsp.read_data;
            check_value("ready_latency", latency, expected_latency);
        end
        @(posedge vdp_clk);
        req.valid <= 1'b0;
        req.wstrb <= 4'h0;
    endtask

    task automatic run_op(input logic [31:0] op_code, input logic [31:0] address,
                          input logic [31:0] wstrb, input logic [31:0] value);
        logic [31:0] read_data;
        case (op_code)
            32'd1: bus_access(address[23:0], wstrb[3:0], value, read_data);
            32'd2: begin
                bus_access(address[23:0], 4'h0, 32'h0, read_data);
                check_value("rsp.read_data", read_data, value);
            end
            32'd3: begin
                @(posedge vdp_clk);
                btn1 <= value[0];
                btn2 <= value[1];
                btn3 <= value[2];
            end
            32'd4: begin
                @(posedge vdp_clk);
                cop_read_address <= address[periph_pkg::cop_addr_width-1:0];
                @(posedge vdp_clk);
                @(negedge vdp_clk);
                check_value("cop_read_data", {16'h0, cop_read_data}, value);
            end
            32'd5: begin
                @(negedge vdp_clk);
                check_value("led_b_led_r", {30'h0, led_b, led_r}, value);
            end
            // pad clock pulses through pad_ctrl writes
            32'd6: begin
                repeat (value) begin
                    bus_access(pad_address, 4'hf, 32'h2, read_data);
                    bus_access(pad_address, 4'hf, 32'h0, read_data);
                end
            end
            default: begin
                error_count++;
                $display("unknown operation %h in the golden file", op_code);
            end
        endcase
    endtask

    initial begin
        check_count      = 0;
        error_count      = 0;
        assert_failures  = 0;
        timed_out        = 1'b0;
        vdp_reset        = 1'b1;
        req              = '0;
        btn1             = 1'b0;
        btn2             = 1'b0;
        btn3             = 1'b0;
        cop_read_address = '0;
        repeat (16) @(posedge vdp_clk);
        vdp_reset <= 1'b0;

        fd = $fopen("bench/peripheral_bus_golden.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open the golden file");
        end else begin
            // comment and blank lines yield fewer than four fields
            while (!$feof(fd) && !timed_out) begin
                got = $fgets(line, fd);
                fields = $sscanf(line, "%h %h %h %h", op, addr, strb, data);
                if (got > 0 && fields == 4) begin
                    run_op(op, addr, strb, data);
                end
            end
            $fclose(fd);
        end

        repeat (2) @(posedge vdp_clk);
        assert_failures = i_dut.i_bus_responder.i_peripheral_bus_asserts.failure_count;
        $display("checks %0d, errors %0d, assertion failures %0d, timeout %0d",
                 check_count, error_count, assert_failures, timed_out);
        if (timed_out || error_count != 0 || assert_failures != 0) begin
            $display("Finished with errors");
        end else begin
            $display("Finished with no errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/peripheral_bus_golden.txt
// columns in hex: op address wstrb data; op 1 write, 2 read (data expected), 3 buttons
// op 4 copper video read (address word, data expected), 5 leds {b,r}, 6 pad clock pulses
5 000000 0 1
2 100000 0 1
1 100000 f 2
5 000000 0 2
2 100000 0 2
1 200000 f fffd
1 200004 f 0007
2 200000 0 ffffffeb
1 200000 f 8000
2 200004 0 fffc8000
3 000000 0 6
1 300000 f 1
1 300000 f 0
2 300000 0 1
6 000000 0 6
2 300000 0 1
6 000000 0 1
2 300000 0 0
1 400010 3 1234
1 400010 c beef
1 400abc 4 c0de
4 008 0 1234
4 009 0 beef
4 55f 0 c0de
2 400010 0 0
2 000010 0 0
1 f00000 f 3
5 000000 0 2
2 100000 0 2

// File: filelist.f
verilog/periph_pkg.sv
verilog/address_decoder.sv
verilog/dsp_multiplier.sv
verilog/gamepad_reader.sv
verilog/copper_ram.sv
verilog/bus_responder.sv
verilog/peripheral_bus.sv
bench/peripheral_bus_asserts.sv
bench/tb_peripheral_bus.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the peripheral bus testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f filelist.f \
    --top-module tb_peripheral_bus -Mdir obj_dir -o sim_peripheral_bus
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_peripheral_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with errors" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation passed"
exit 0
